/* Makefile */
# Verilator build and run for the vector execute stage

VERILATOR   ?= verilator
FILELIST    := sim.f
TOP         := vexe_tb
RTL_TOP     := vexe_stage
BUILD_DIR   := obj_dir
LOG         := sim.log
FAIL_MSG    := Simulation failed
SIM_FLAGS   := --binary --timing --assert -j 0
LINT_FLAGS  := --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINT_FLAGS) +incdir+include design/vexe_types_pkg.sv \
		design/vexe_op_pkg.sv design/vexe_bypass.sv design/vexe_element_ctrl.sv \
		design/vexe_lane_alu.sv design/vexe_stage.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* design/vexe_bypass.sv */
// Operand forwarding network
// Picks the newest value of vs1, vs2, old vd and v0 from the
// memory stage, the write-back stage or the register file read

`default_nettype none

module vexe_bypass
    import vexe_types_pkg::*;
    import vexe_op_pkg::*;
(
    input  vexe_issue_t issue,
    input  vreg_data_t  vs1_data,
    input  vreg_data_t  vs2_data,
    input  vreg_data_t  vd_old_data,
    input  vreg_data_t  v0_data,
    input  vexe_fwd_t   fwd_mem,
    input  vexe_fwd_t   fwd_wb,
    output vreg_data_t  vs1_byp,
    output vreg_data_t  vs2_byp,
    output vreg_data_t  vd_old_byp,
    output vreg_data_t  v0_byp
);

    // Memory stage is newer than write-back, so it is checked first
    function automatic vreg_data_t pick_newest(
        input vreg_addr_t addr,
        input vreg_data_t rf_data,
        input vexe_fwd_t  mem,
        input vexe_fwd_t  wb
    );
        vreg_data_t sel;
        if (mem.wr_en && (mem.addr == addr)) begin
            sel = mem.data;
        end else if (wb.wr_en && (wb.addr == addr)) begin
            sel = wb.data;
        end else begin
            sel = rf_data;
        end
        return sel;
    endfunction

    always_comb begin
        vs1_byp    = pick_newest(issue.vs1, vs1_data, fwd_mem, fwd_wb);
        vs2_byp    = pick_newest(issue.vs2, vs2_data, fwd_mem, fwd_wb);
        vd_old_byp = pick_newest(issue.vd, vd_old_data, fwd_mem, fwd_wb);
        // Mask register is always v0
        v0_byp     = pick_newest(vreg_addr_t'(0), v0_data, fwd_mem, fwd_wb);
    end

    // A writing stage must present a resolved address
    always_comb begin
        if (fwd_mem.wr_en === 1'b1) begin
            assert (!$isunknown(fwd_mem.addr))
                else $error("fwd_mem write with unknown address");
        end
        if (fwd_wb.wr_en === 1'b1) begin
            assert (!$isunknown(fwd_wb.addr))
                else $error("fwd_wb write with unknown address");
        end
    end

endmodule

`default_nettype wire

/* design/vexe_element_ctrl.sv */
// Element control
// Turns element width, vl and the v0 mask into per-byte write enables

`default_nettype none

`include "vexe_defines.svh"

module vexe_element_ctrl
    import vexe_types_pkg::*;
(
    input  sew_e       sew,
    input  vl_t        vl,
    input  logic       masked,
    input  vreg_data_t v0,
    output byte_en_t   byte_en
);

    localparam int NUM_BYTES = $bits(byte_en_t);

    vl_t                        elem_count;
    logic [`VEXE_MAX_ELEMS-1:0] elem_en;

    always_comb begin
        case (sew)
            SEW8:    elem_count = vl_t'(`VEXE_VLEN / 8);
            SEW16:   elem_count = vl_t'(`VEXE_VLEN / 16);
            SEW32:   elem_count = vl_t'(`VEXE_VLEN / 32);
            default: elem_count = '0;
        endcase
    end

    // Element is active below vl and, when masked, with its v0 bit set
    always_comb begin
        for (int i = 0; i < `VEXE_MAX_ELEMS; i++) begin
            elem_en[i] = (i < int'(elem_count)) && (i < int'(vl)) && (!masked || v0[i]);
        end
    end

    // Spread each element enable over its bytes
    always_comb begin
        for (int b = 0; b < NUM_BYTES; b++) begin
            byte_en[b] = elem_en[b >> sew];
        end
    end

    // vl above VLEN/SEW is an illegal configuration
    always_comb begin
        if (!$isunknown({sew, vl})) begin
            assert (vl <= elem_count)
                else $error("vl %0d exceeds element count %0d", vl, elem_count);
        end
    end

endmodule

`default_nettype wire

/* design/vexe_lane_alu.sv */
// Width-segmented vector ALU
// Selects the second operand, runs the operation per element,
// merges inactive bytes with old vd and registers the result

`default_nettype none

`include "vexe_defines.svh"

module vexe_lane_alu
    import vexe_types_pkg::*;
    import vexe_op_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  vexe_issue_t  issue,
    input  vreg_data_t   vs1,
    input  vreg_data_t   vs2,
    input  vreg_data_t   vd_old,
    input  xlen_data_t   scalar,
    input  byte_en_t     byte_en,
    output vexe_result_t result
);

    localparam int NUM_SEW = 3;

    xlen_data_t imm_ext;
    xlen_data_t splat_src;
    vreg_data_t seg_res [NUM_SEW];
    vreg_data_t alu_out;
    vreg_data_t merged;

    // One element of width w, operands zero-extended to 32 bits
    function automatic logic [31:0] elem_alu(
        input vexe_opcode_e op,
        input logic [31:0]  a,
        input logic [31:0]  b,
        input int unsigned  w
    );
        logic [31:0] sign;
        logic [31:0] sa;
        logic [31:0] sb;
        logic [4:0]  sh;
        logic [31:0] res;
        sign = 32'(1) << (w - 1);
        // Sign-extend from bit w-1
        sa = (a ^ sign) - sign;
        sb = (b ^ sign) - sign;
        sh = b[4:0] & 5'(w - 1);
        case (op)
            ADD:     res = a + b;
            SUB:     res = a - b;
            AND:     res = a & b;
            OR:      res = a | b;
            XOR:     res = a ^ b;
            MIN:     res = ($signed(sa) < $signed(sb)) ? a : b;
            MINU:    res = (a < b) ? a : b;
            MAX:     res = ($signed(sa) > $signed(sb)) ? a : b;
            MAXU:    res = (a > b) ? a : b;
            SLL:     res = a << sh;
            SRL:     res = a >> sh;
            SRA:     res = 32'($signed(sa) >>> sh);
            default: res = '0;
        endcase
        return res;
    endfunction

    // Scalar or immediate, truncated per element below
    assign imm_ext   = {{(`VEXE_XLEN-5){issue.imm5[4]}}, issue.imm5};
    assign splat_src = (issue.form == VX) ? scalar : imm_ext;

    // Carries and shifts stay inside each element
    for (genvar s = 0; s < NUM_SEW; s++) begin : g_sew
        localparam int W = 8 << s;
        for (genvar e = 0; e < `VEXE_VLEN / W; e++) begin : g_elem
            logic [W-1:0] op_b;
            assign op_b = (issue.form == VV) ? vs1[e*W +: W] : splat_src[W-1:0];
            assign seg_res[s][e*W +: W] =
                W'(elem_alu(issue.opcode, 32'(vs2[e*W +: W]), 32'(op_b), W));
        end
    end

    always_comb begin
        case (issue.sew)
            SEW8:    alu_out = seg_res[0];
            SEW16:   alu_out = seg_res[1];
            SEW32:   alu_out = seg_res[2];
            default: alu_out = '0;
        endcase
    end

    // Undisturbed policy for inactive bytes
    always_comb begin
        for (int b = 0; b < $bits(byte_en_t); b++) begin
            merged[b*8 +: 8] = byte_en[b] ? alu_out[b*8 +: 8] : vd_old[b*8 +: 8];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else begin
            result.valid <= issue.valid;
            if (issue.valid) begin
                result.vd   <= issue.vd;
                result.data <= merged;
            end
        end
    end

    a_legal_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        issue.valid |-> (!$isunknown(issue.opcode) && (issue.opcode <= SRA))
    ) else $error("illegal opcode %0d on valid issue", issue.opcode);

endmodule

`default_nettype wire

/* design/vexe_op_pkg.sv */
// Operation types of the vector execute stage
// Opcode and operand form, plus issue, forward and result records

`default_nettype none

package vexe_op_pkg;
    import vexe_types_pkg::*;

    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        MIN  = 4'd5,
        MINU = 4'd6,
        MAX  = 4'd7,
        MAXU = 4'd8,
        SLL  = 4'd9,
        SRL  = 4'd10,
        SRA  = 4'd11
    } vexe_opcode_e;

    // Second operand source
    typedef enum logic [1:0] {
        VV = 2'd0,
        VX = 2'd1,
        VI = 2'd2
    } vexe_form_e;

    typedef struct packed {
        logic         valid;
        vexe_opcode_e opcode;
        vexe_form_e   form;
        sew_e         sew;
        vl_t          vl;
        logic         masked;
        vreg_addr_t   vs1;
        vreg_addr_t   vs2;
        vreg_addr_t   vd;
        logic [4:0]   imm5;
    } vexe_issue_t;

    // Register write from a later pipeline stage
    typedef struct packed {
        logic       wr_en;
        vreg_addr_t addr;
        vreg_data_t data;
    } vexe_fwd_t;

    typedef struct packed {
        logic       valid;
        vreg_addr_t vd;
        vreg_data_t data;
    } vexe_result_t;

endpackage

`default_nettype wire

/* design/vexe_stage.sv */
// Vector execute stage top level
// Forwarding, element enables and the registered lane ALU,
// one result per issue with a fixed latency of one cycle

`default_nettype none

module vexe_stage
    import vexe_types_pkg::*;
    import vexe_op_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  vexe_issue_t  issue,
    input  vreg_data_t   vs1_data,
    input  vreg_data_t   vs2_data,
    input  vreg_data_t   vd_old_data,
    input  vreg_data_t   v0_data,
    input  xlen_data_t   scalar,
    input  vexe_fwd_t    fwd_mem,
    input  vexe_fwd_t    fwd_wb,
    output vexe_result_t result
);

    vreg_data_t vs1_byp;
    vreg_data_t vs2_byp;
    vreg_data_t vd_old_byp;
    vreg_data_t v0_byp;
    byte_en_t   byte_en;

    vexe_bypass vexe_bypass_i (
        .issue       (issue),
        .vs1_data    (vs1_data),
        .vs2_data    (vs2_data),
        .vd_old_data (vd_old_data),
        .v0_data     (v0_data),
        .fwd_mem     (fwd_mem),
        .fwd_wb      (fwd_wb),
        .vs1_byp     (vs1_byp),
        .vs2_byp     (vs2_byp),
        .vd_old_byp  (vd_old_byp),
        .v0_byp      (v0_byp)
    );

    // Mask uses the forwarded v0
    vexe_element_ctrl vexe_element_ctrl_i (
        .sew     (issue.sew),
        .vl      (issue.vl),
        .masked  (issue.masked),
        .v0      (v0_byp),
        .byte_en (byte_en)
    );

    vexe_lane_alu vexe_lane_alu_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .issue   (issue),
        .vs1     (vs1_byp),
        .vs2     (vs2_byp),
        .vd_old  (vd_old_byp),
        .scalar  (scalar),
        .byte_en (byte_en),
        .result  (result)
    );

endmodule

`default_nettype wire

/* design/vexe_types_pkg.sv */
// Data-path types of the vector execute stage
// Register values, addresses, byte enables, vl and element width

`default_nettype none

`include "vexe_defines.svh"

package vexe_types_pkg;

    // One full vector register
    typedef logic [`VEXE_VLEN-1:0] vreg_data_t;

    // Vector register number
    typedef logic [`VEXE_VREG_ADDR_W-1:0] vreg_addr_t;

    // One enable per data byte
    typedef logic [`VEXE_VLEN/8-1:0] byte_en_t;

    // Active element count, 0 up to the element limit
    typedef logic [$clog2(`VEXE_MAX_ELEMS+1)-1:0] vl_t;

    // Scalar operand from the integer side
    typedef logic [`VEXE_XLEN-1:0] xlen_data_t;

    // Element width, encoded as log2(SEW/8)
    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } sew_e;

endpackage

`default_nettype wire

/* include/vexe_defines.svh */
// Vector execute stage parameters
// Register width, register file size and element count limits

`ifndef VEXE_DEFINES_SVH
`define VEXE_DEFINES_SVH

// Vector register width in bits
`define VEXE_VLEN 64

// Number of architectural vector registers
`define VEXE_VREG_COUNT 32
`define VEXE_VREG_ADDR_W $clog2(`VEXE_VREG_COUNT)

// Elements per register at the narrowest width
`define VEXE_MAX_ELEMS (`VEXE_VLEN / 8)

// Scalar operand width
`define VEXE_XLEN 32

`endif

/* sim.f */
+incdir+include
design/vexe_types_pkg.sv
design/vexe_op_pkg.sv
design/vexe_bypass.sv
design/vexe_element_ctrl.sv
design/vexe_lane_alu.sv
design/vexe_stage.sv
verif/vexe_tb.sv

/* verif/vexe_tb.sv */
// Testbench for the vector execute stage
// Random and directed issues checked against a reference model

`default_nettype none

`include "vexe_defines.svh"

module vexe_tb
    import vexe_types_pkg::*;
    import vexe_op_pkg::*;
;

    localparam vexe_fwd_t NO_FWD = '0;

    logic         clk;
    logic         rst_n;
    vexe_issue_t  issue;
    vreg_data_t   vs1_data;
    vreg_data_t   vs2_data;
    vreg_data_t   vd_old_data;
    vreg_data_t   v0_data;
    xlen_data_t   scalar;
    vexe_fwd_t    fwd_mem;
    vexe_fwd_t    fwd_wb;
    vexe_result_t result;

    vexe_result_t exp_q[$];
    int           due_q[$];
    vexe_result_t cmp_exp;
    int           cmp_due;
    int           cyc = 0;
    int           checks = 0;
    int           errors = 0;
    int           test_errs = 0;
    int           seed;
    string        test_name = "none";
    vexe_issue_t  iss;
    vreg_data_t   d_a;
    vreg_data_t   d_b;
    vexe_opcode_e shift_ops[4] = '{SLL, SRL, SRA, ADD};

    vexe_stage vexe_stage_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .issue       (issue),
        .vs1_data    (vs1_data),
        .vs2_data    (vs2_data),
        .vd_old_data (vd_old_data),
        .v0_data     (v0_data),
        .scalar      (scalar),
        .fwd_mem     (fwd_mem),
        .fwd_wb      (fwd_wb),
        .result      (result)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cyc++;

    // Newest source value, memory stage first
    function automatic vreg_data_t resolve_src(
        input vreg_addr_t addr,
        input vreg_data_t rf,
        input vexe_fwd_t  fm,
        input vexe_fwd_t  fw
    );
        if (fm.wr_en && fm.addr == addr) return fm.data;
        if (fw.wr_en && fw.addr == addr) return fw.data;
        return rf;
    endfunction

    function automatic vreg_data_t ref_execute(
        input vexe_issue_t i_rec,
        input vreg_data_t  rf_vs1,
        input vreg_data_t  rf_vs2,
        input vreg_data_t  rf_old,
        input vreg_data_t  rf_v0,
        input xlen_data_t  sc,
        input vexe_fwd_t   fm,
        input vexe_fwd_t   fw
    );
        vreg_data_t  s1;
        vreg_data_t  s2;
        vreg_data_t  v0;
        vreg_data_t  res;
        logic [63:0] m;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] r;
        longint      sa;
        longint      sb;
        int          w;
        int          sh;
        s1  = resolve_src(i_rec.vs1, rf_vs1, fm, fw);
        s2  = resolve_src(i_rec.vs2, rf_vs2, fm, fw);
        res = resolve_src(i_rec.vd, rf_old, fm, fw);
        v0  = resolve_src(vreg_addr_t'(0), rf_v0, fm, fw);
        w   = 8 << int'(i_rec.sew);
        m   = (64'd1 << w) - 64'd1;
        for (int e = 0; e < `VEXE_VLEN / w; e++) begin
            a = (s2 >> (e * w)) & m;
            case (i_rec.form)
                VV:      b = (s1 >> (e * w)) & m;
                VX:      b = 64'(sc) & m;
                default: b = 64'($signed(i_rec.imm5)) & m;
            endcase
            sa = longint'(a);
            sb = longint'(b);
            if (a[w-1]) sa -= longint'(1) << w;
            if (b[w-1]) sb -= longint'(1) << w;
            sh = int'(b[4:0]) % w;
            case (i_rec.opcode)
                ADD:     r = a + b;
                SUB:     r = a - b;
                AND:     r = a & b;
                OR:      r = a | b;
                XOR:     r = a ^ b;
                MIN:     r = (sa < sb) ? a : b;
                MINU:    r = (a < b) ? a : b;
                MAX:     r = (sa > sb) ? a : b;
                MAXU:    r = (a > b) ? a : b;
                SLL:     r = a << sh;
                SRL:     r = a >> sh;
                SRA:     r = sa >>> sh;
                default: r = '0;
            endcase
            // Inactive elements keep old vd
            if (e < int'(i_rec.vl) && (!i_rec.masked || v0[e])) begin
                res = (res & ~(m << (e * w))) | ((r & m) << (e * w));
            end
        end
        return res;
    endfunction

    function automatic vreg_data_t rand_data();
        return {$urandom(), $urandom()};
    endfunction

    function automatic vexe_fwd_t make_fwd(input logic en, input vreg_addr_t a,
                                           input vreg_data_t d);
        vexe_fwd_t f;
        f.wr_en = en;
        f.addr  = a;
        f.data  = d;
        return f;
    endfunction

    function automatic vexe_issue_t rand_issue();
        vexe_issue_t r;
        r.valid  = 1'b1;
        r.opcode = vexe_opcode_e'($urandom_range(0, 11));
        r.form   = vexe_form_e'($urandom_range(0, 2));
        r.sew    = sew_e'($urandom_range(0, 2));
        r.vl     = vl_t'($urandom_range(0, `VEXE_MAX_ELEMS >> int'(r.sew)));
        r.masked = 1'($urandom_range(0, 1));
        r.vs1    = vreg_addr_t'($urandom_range(1, 31));
        r.vs2    = vreg_addr_t'($urandom_range(1, 31));
        r.vd     = vreg_addr_t'($urandom_range(1, 31));
        r.imm5   = 5'($urandom_range(0, 31));
        return r;
    endfunction

    task automatic check_data(input string name, input vreg_data_t exp, input vreg_data_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s data: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input vreg_addr_t exp, input vreg_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("MISMATCH %s vd: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic finish_run();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    // Drive one issue and queue its expected result
    task automatic send(input vexe_issue_t i_rec, input vreg_data_t d1, input vreg_data_t d2,
                        input vreg_data_t dold, input vreg_data_t dv0, input xlen_data_t sc,
                        input vexe_fwd_t fm, input vexe_fwd_t fw);
        vexe_result_t exp;
        @(posedge clk);
        #2;
        issue       = i_rec;
        vs1_data    = d1;
        vs2_data    = d2;
        vd_old_data = dold;
        v0_data     = dv0;
        scalar      = sc;
        fwd_mem     = fm;
        fwd_wb      = fw;
        if (i_rec.valid) begin
            exp.valid = 1'b1;
            exp.vd    = i_rec.vd;
            exp.data  = ref_execute(i_rec, d1, d2, dold, dv0, sc, fm, fw);
            exp_q.push_back(exp);
            due_q.push_back(cyc + 1);
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_errs = errors;
    endtask

    task automatic end_test();
        int waited;
        @(posedge clk);
        #2;
        issue   = '0;
        fwd_mem = NO_FWD;
        fwd_wb  = NO_FWD;
        waited  = 0;
        while (exp_q.size() != 0 && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Timeout in %s: %0d results never arrived", test_name, exp_q.size());
            finish_run();
        end else begin
            $display("test %s finished with %0d errors", test_name, errors - test_errs);
        end
    endtask

    // Results are sampled mid-cycle, away from the clock edge
    always @(negedge clk) begin
        if (rst_n && result.valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("Result in %s arrived with no issue pending", test_name);
            end else begin
                cmp_exp = exp_q.pop_front();
                cmp_due = due_q.pop_front();
                check_addr(test_name, cmp_exp.vd, result.vd);
                check_data(test_name, cmp_exp.data, result.data);
                if (cyc != cmp_due) begin
                    errors++;
                    $display("Result in %s came in cycle %0d, not %0d", test_name, cyc, cmp_due);
                end
            end
        end
    end

    initial begin
        seed        = $urandom(32'h2e79_59db);
        clk         = 1'b0;
        rst_n       = 1'b0;
        issue       = '0;
        // Valid issue held through reset must not reach the output
        issue.valid = 1'b1;
        vs1_data    = '0;
        vs2_data    = '0;
        vd_old_data = '0;
        v0_data     = '0;
        scalar      = '0;
        fwd_mem     = NO_FWD;
        fwd_wb      = NO_FWD;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        issue = '0;

        start_test("reset_add");
        @(negedge clk);
        checks++;
        if (result.valid !== 1'b0) begin
            errors++;
            $display("Result valid is high after reset");
        end
        for (int s = 0; s < 3; s++) begin
            iss        = rand_issue();
            iss.opcode = ADD;
            iss.form   = VV;
            iss.sew    = sew_e'(s);
            iss.vl     = vl_t'(`VEXE_MAX_ELEMS >> s);
            iss.masked = 1'b0;
            // All-ones plus one wraps inside every element
            send(iss, 64'h0101_0101_0101_0101, '1, rand_data(), rand_data(), '0, NO_FWD, NO_FWD);
            send(iss, rand_data(), rand_data(), rand_data(), rand_data(), '0, NO_FWD, NO_FWD);
        end
        end_test();

        start_test("vv_ops");
        for (int k = 0; k < 40; k++) begin
            iss        = rand_issue();
            iss.opcode = vexe_opcode_e'($urandom_range(1, 8));
            iss.form   = VV;
            iss.vl     = vl_t'(`VEXE_MAX_ELEMS >> int'(iss.sew));
            iss.masked = 1'b0;
            d_a        = rand_data();
            d_b        = rand_data();
            if (k % 4 == 0) d_a |= 64'h8080_8080_8080_8080;
            if (k % 3 == 0) d_b |= 64'h8000_8000_8000_8000;
            send(iss, d_a, d_b, rand_data(), rand_data(), '0, NO_FWD, NO_FWD);
        end
        end_test();

        start_test("vx_vi_shift");
        for (int k = 0; k < 40; k++) begin
            iss        = rand_issue();
            iss.opcode = shift_ops[$urandom_range(0, 3)];
            iss.form   = (k % 2 == 0) ? VX : VI;
            iss.vl     = vl_t'(`VEXE_MAX_ELEMS >> int'(iss.sew));
            iss.masked = 1'b0;
            send(iss, rand_data(), rand_data(), rand_data(), rand_data(), $urandom(),
                 NO_FWD, NO_FWD);
        end
        end_test();

        start_test("vl_mask");
        for (int k = 0; k < 30; k++) begin
            iss        = rand_issue();
            iss.vl     = vl_t'($urandom_range(0, (`VEXE_MAX_ELEMS >> int'(iss.sew)) - 1));
            iss.masked = 1'b1;
            send(iss, rand_data(), rand_data(), rand_data(), rand_data(), $urandom(),
                 NO_FWD, NO_FWD);
        end
        for (int s = 0; s < 3; s++) begin
            iss     = rand_issue();
            iss.sew = sew_e'(s);
            iss.vl  = '0;
            send(iss, rand_data(), rand_data(), rand_data(), rand_data(), $urandom(),
                 NO_FWD, NO_FWD);
        end
        end_test();

        start_test("forward");
        iss        = rand_issue();
        iss.opcode = ADD;
        iss.form   = VV;
        iss.sew    = SEW8;
        iss.vl     = vl_t'(`VEXE_MAX_ELEMS);
        iss.masked = 1'b0;
        iss.vs1    = 5'd3;
        iss.vs2    = 5'd4;
        iss.vd     = 5'd5;
        send(iss, rand_data(), rand_data(), rand_data(), rand_data(), '0,
             make_fwd(1'b1, 5'd3, rand_data()), make_fwd(1'b1, 5'd3, rand_data()));
        send(iss, rand_data(), rand_data(), rand_data(), rand_data(), '0,
             make_fwd(1'b0, 5'd4, rand_data()), make_fwd(1'b1, 5'd4, rand_data()));
        // Register file v0 is all zero, so only the forwarded mask enables elements
        iss.masked = 1'b1;
        send(iss, rand_data(), rand_data(), rand_data(), '0, '0,
             NO_FWD, make_fwd(1'b1, 5'd0, 64'h5a));
        send(iss, rand_data(), rand_data(), rand_data(), '0, '0,
             make_fwd(1'b1, 5'd0, 64'hc3), make_fwd(1'b1, 5'd0, 64'h3c));
        end_test();

        start_test("back_to_back");
        for (int c = 0; c < 200; c++) begin
            iss       = rand_issue();
            iss.valid = ($urandom_range(0, 3) != 0);
            iss.vs1   = vreg_addr_t'($urandom_range(0, 3));
            iss.vs2   = vreg_addr_t'($urandom_range(0, 3));
            iss.vd    = vreg_addr_t'($urandom_range(0, 31));
            send(iss, rand_data(), rand_data(), rand_data(), rand_data(), $urandom(),
                 make_fwd(1'($urandom_range(0, 1)), vreg_addr_t'($urandom_range(0, 3)),
                          rand_data()),
                 make_fwd(1'($urandom_range(0, 1)), vreg_addr_t'($urandom_range(0, 3)),
                          rand_data()));
        end
        end_test();

        finish_run();
    end

endmodule

`default_nettype wire
